//--- verif/mem_burst_tests.txt
# W addr len, then len+1 pairs of data and strobe; R addr len, then len+1 expected beats
# P addr len writes the address pattern; Q addr len reads it back (all fields in hex)
# never written words read as zero after the clear
R 0000100 7
  00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
# aligned full word
W 0000000 7
  a0000001 f a0000002 f a0000003 f a0000004 f
  a0000005 f a0000006 f a0000007 f a0000008 f
R 0000000 7
  a0000001 a0000002 a0000003 a0000004 a0000005 a0000006 a0000007 a0000008
# start at lane 5 of word 2 and cross into word 3
W 0000054 5
  b0000001 f b0000002 f b0000003 f b0000004 f b0000005 f b0000006 f
R 0000054 5
  b0000001 b0000002 b0000003 b0000004 b0000005 b0000006
# all of word 2 and the head of word 3, lanes 0 to 4 never written
R 0000040 a
  00000000 00000000 00000000 00000000 00000000
  b0000001 b0000002 b0000003 b0000004 b0000005 b0000006
# single beat burst
R 0000058 0
  b0000002
# partial strobes over lanes 2 and 3 of word 0
W 0000008 1
  ccddeeff 5 12345678 c
R 0000000 7
  a0000001 a0000002 a0dd00ff 12340004 a0000005 a0000006 a0000007 a0000008
# fill all 64 words with the address pattern and read them back
P 0000000 ff
P 0000400 ff
Q 0000000 ff
Q 0000400 ff
# word indices 64 and up alias onto words 0 to 63
Q 0000800 ff
Q 00007f4 f

//--- src.f
hdl/mem_slave_pkg.sv
hdl/write_beat_packer.sv
hdl/read_beat_splitter.sv
hdl/wide_word_store.sv
hdl/mem_burst_slave.sv
verif/tb_clock_gen.sv
verif/mem_burst_checker.sv
verif/mem_burst_slave_tb.sv

//--- Bender.yml
package:
  name: mem_burst_slave

sources:
  - files:
      - hdl/mem_slave_pkg.sv
      - hdl/write_beat_packer.sv
      - hdl/read_beat_splitter.sv
      - hdl/wide_word_store.sv
      - hdl/mem_burst_slave.sv
  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/mem_burst_checker.sv
      - verif/mem_burst_slave_tb.sv

//--- verif/mem_burst_slave_tb.sv
`timescale 1ns/100ps

module mem_burst_slave_tb;
    import mem_slave_pkg::*;

    logic       clk;
    logic       rst;
    logic       init_done;
    burst_cmd_t wr_cmd;
    logic       wr_cmd_valid;
    logic       wr_cmd_ready;
    wr_beat_t   wr_beat;
    logic       wr_beat_valid;
    logic       wr_beat_ready;
    burst_cmd_t rd_cmd;
    logic       rd_cmd_valid;
    logic       rd_cmd_ready;
    rd_beat_t   rd_beat;
    logic       rd_beat_valid;
    logic       rd_beat_ready;

    byte                       cmd_kind  [$];   // W R P Q
    logic [ADDR_BITS-1:0]      cmd_addr  [$];
    int                        cmd_len   [$];
    int                        cmd_first [$];   // first entry in the value queues
    logic [BEAT_BITS-1:0]      val_data  [$];
    logic [BEAT_STRB_BITS-1:0] val_strb  [$];
    int                        total_beats     = 0;
    int                        watchdog_cycles = 0;
    logic [31:0]               lfsr            = 32'hc2b5_d1f7;

    tb_clock_gen i_clk (.clk(clk), .rst(rst));

    mem_burst_slave i_dut (.*);

    mem_burst_checker i_chk (.*);

    // galois lfsr, one step per bit taken
    function automatic logic rand_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) begin
            lfsr = lfsr ^ 32'h8020_0003;
        end
        return b;
    endfunction

    function automatic logic quarter_chance();
        logic a;
        logic b;
        a = rand_bit();
        b = rand_bit();
        return a && b;
    endfunction

    // distinct value for every beat address
    function automatic logic [BEAT_BITS-1:0] addr_pattern(input logic [ADDR_BITS-1:0] a);
        return {4'hc, a} ^ 32'h0055_aa00;
    endfunction

    task automatic load_tests();
        int                        fd;
        int                        c;
        int                        len;
        string                     tok;
        logic [ADDR_BITS-1:0]      addr;
        logic [BEAT_BITS-1:0]      data;
        logic [BEAT_STRB_BITS-1:0] strb;
        bit                        ok;
        fd = $fopen("verif/mem_burst_tests.txt", "r");
        ok = (fd != 0);
        if (!ok) begin
            i_chk.note_error("cannot open the tests file verif/mem_burst_tests.txt");
        end
        while (ok && $fscanf(fd, " %s", tok) == 1) begin
            if (tok.getc(0) == "#") begin
                c = 0;
                while (c != "\n" && c != -1) begin
                    c = $fgetc(fd);             // skip the comment line
                end
            end else if (tok != "W" && tok != "R" && tok != "P" && tok != "Q") begin
                i_chk.note_error({"unknown command in the tests file: ", tok});
                ok = 0;
            end else if ($fscanf(fd, " %h %h", addr, len) != 2 || len > 255) begin
                i_chk.note_error({"bad address or length after command ", tok});
                ok = 0;
            end else begin
                cmd_kind.push_back(tok.getc(0));
                cmd_addr.push_back(addr);
                cmd_len.push_back(len);
                cmd_first.push_back(val_data.size());
                total_beats += len + 1;
                for (int i = 0; i <= len && ok; i++) begin
                    data = '0;
                    strb = '0;
                    if (tok == "W") begin
                        ok = ($fscanf(fd, " %h %h", data, strb) == 2);
                    end else if (tok == "R") begin
                        ok = ($fscanf(fd, " %h", data) == 1);
                    end
                    val_data.push_back(data);
                    val_strb.push_back(strb);
                end
                if (!ok) begin
                    i_chk.note_error("the tests file ends inside a burst");
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
    endtask

    task automatic drive_write(input int k);
        logic [ADDR_BITS-1:0] beat_addr;
        logic                 pattern;
        int                   first;
        pattern = (cmd_kind[k] == "P");
        first = cmd_first[k];
        wr_cmd.addr.flat = cmd_addr[k];
        wr_cmd.len = LEN_BITS'(cmd_len[k]);
        wr_cmd_valid = 1'b1;
        do @(posedge clk); while (!wr_cmd_ready);
        #1;
        wr_cmd_valid = 1'b0;
        for (int i = 0; i <= cmd_len[k]; i++) begin
            while (quarter_chance()) begin
                @(posedge clk);                 // idle gap before the beat
                #1;
            end
            beat_addr = cmd_addr[k] + ADDR_BITS'(4 * i);
            wr_beat.data = pattern ? addr_pattern(beat_addr) : val_data[first + i];
            wr_beat.strb = pattern ? 4'hf : val_strb[first + i];
            wr_beat.last = (i == cmd_len[k]);
            wr_beat_valid = 1'b1;
            do @(posedge clk); while (!wr_beat_ready);
            #1;
            wr_beat_valid = 1'b0;
        end
    endtask

    task automatic drive_read(input int k);
        logic [ADDR_BITS-1:0] beat_addr;
        logic [BEAT_BITS-1:0] expected;
        logic                 taken;
        for (int i = 0; i <= cmd_len[k]; i++) begin
            beat_addr = cmd_addr[k] + ADDR_BITS'(4 * i);
            if (cmd_kind[k] == "Q") begin
                // only 64 words exist, higher word indices wrap onto them
                expected = addr_pattern(ADDR_BITS'(beat_addr % (STORE_WORDS * WORD_BITS / 8)));
            end else begin
                expected = val_data[cmd_first[k] + i];
            end
            i_chk.expect_beat(expected, i == cmd_len[k]);
        end
        rd_cmd.addr.flat = cmd_addr[k];
        rd_cmd.len = LEN_BITS'(cmd_len[k]);
        rd_cmd_valid = 1'b1;
        taken = 1'b0;
        while (!taken || i_chk.pending() != 0) begin
            @(posedge clk);
            if (rd_cmd_valid && rd_cmd_ready) begin
                taken = 1'b1;
            end
            #1;
            if (taken) begin
                rd_cmd_valid = 1'b0;
            end
            rd_beat_ready = !quarter_chance();  // random stalls
        end
        rd_beat_ready = 1'b0;
    endtask

    initial begin
        wr_cmd        = '0;
        wr_cmd_valid  = 1'b0;
        wr_beat       = '0;
        wr_beat_valid = 1'b0;
        rd_cmd        = '0;
        rd_cmd_valid  = 1'b0;
        rd_beat_ready = 1'b0;
        load_tests();
        watchdog_cycles = (total_beats + 64) * 20 + STORE_WORDS + 16;
        wait (rst === 1'b0);
        do @(posedge clk); while (!init_done);
        #1;
        for (int k = 0; k < cmd_kind.size(); k++) begin
            if (cmd_kind[k] == "W" || cmd_kind[k] == "P") begin
                drive_write(k);
            end else begin
                drive_read(k);
            end
        end
        rd_beat_ready = 1'b1;                   // take any extra beat
        repeat (8) @(posedge clk);              // room for a stray read beat
        i_chk.finish_checks();
        if (i_chk.error_count() == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // watchdog, budget set once the tests are loaded
    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        i_chk.note_error($sformatf("the run timed out after %0d cycles", watchdog_cycles));
        i_chk.finish_checks();
        $display("Regression failed");
        $finish;
    end

endmodule

//--- verif/mem_burst_checker.sv
`timescale 1ns/100ps

module mem_burst_checker (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    init_done,
    input  mem_slave_pkg::rd_beat_t rd_beat,
    input  logic                    rd_beat_valid,
    input  logic                    rd_beat_ready
);
    import mem_slave_pkg::*;

    logic [BEAT_BITS-1:0] exp_data [$];
    logic                 exp_last [$];
    int                   beats_seen   = 0;
    int                   data_errors  = 0;
    int                   last_errors  = 0;
    int                   other_errors = 0;
    int                   clear_cycles = 0;     // cycles before init_done
    logic                 init_seen;
    logic                 held;                 // beat offered but not taken
    rd_beat_t             held_beat;

    task automatic expect_beat(input logic [BEAT_BITS-1:0] data, input logic last);
        exp_data.push_back(data);
        exp_last.push_back(last);
    endtask

    function automatic int pending();
        return exp_data.size();
    endfunction

    function automatic int error_count();
        return data_errors + last_errors + other_errors;
    endfunction

    task automatic note_error(input string what);
        other_errors++;
        $display("ERROR at %0t ns: %s", $time, what);
    endtask

    task automatic print_counts();
        $display("read beats %0d, data mismatches %0d, last mismatches %0d, other errors %0d",
                 beats_seen, data_errors, last_errors, other_errors);
    endtask

    task automatic finish_checks();
        if (exp_data.size() != 0) begin
            note_error($sformatf("%0d expected read beats never arrived", exp_data.size()));
        end
        print_counts();
    endtask

    task automatic compare_beat();
        logic [BEAT_BITS-1:0] data;
        logic                 last;
        if (exp_data.size() == 0) begin
            note_error("a read beat arrived with no expectation");
        end else begin
            data = exp_data.pop_front();
            last = exp_last.pop_front();
            if (rd_beat.data !== data) begin
                data_errors++;
                $display("MISMATCH rd_beat.data: got %h, expected %h (beat %0d)",
                         rd_beat.data, data, beats_seen);
            end
            if (rd_beat.last !== last) begin
                last_errors++;
                $display("MISMATCH rd_beat.last: got %h, expected %h (beat %0d)",
                         rd_beat.last, last, beats_seen);
            end
        end
        beats_seen++;
    endtask

    always @(posedge clk) begin
        if (rst) begin
            held         <= 1'b0;
            init_seen    <= 1'b0;
            clear_cycles <= 0;
        end else begin
            // clear phase takes one cycle per store word
            if (init_seen && !init_done) begin
                note_error("init_done dropped after it was set");
            end
            if (!init_seen && init_done && clear_cycles != STORE_WORDS) begin
                note_error($sformatf("init_done rose after %0d clear cycles instead of %0d",
                                     clear_cycles, STORE_WORDS));
            end
            if (!init_done) begin
                clear_cycles <= clear_cycles + 1;
            end
            init_seen <= init_seen || init_done;
            // a stalled beat has to stay put until it is taken
            if (held && (!rd_beat_valid || rd_beat !== held_beat)) begin
                note_error("a read beat was dropped or changed while rd_beat_ready was low");
            end
            if (rd_beat_valid && rd_beat_ready) begin
                compare_beat();
            end
            held      <= rd_beat_valid && !rd_beat_ready;
            held_beat <= rd_beat;
        end
    end

endmodule

//--- verif/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;                 // 40 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (16) @(posedge clk);
        #1 rst = 1'b0;                          // released just after an edge
    end

endmodule

//--- hdl/mem_burst_slave.sv
`timescale 1ns/100ps

module mem_burst_slave (
    input  logic                      clk,
    input  logic                      rst,
    output logic                      init_done,

    input  mem_slave_pkg::burst_cmd_t wr_cmd,         // write command
    input  logic                      wr_cmd_valid,
    output logic                      wr_cmd_ready,

    input  mem_slave_pkg::wr_beat_t   wr_beat,        // write data
    input  logic                      wr_beat_valid,
    output logic                      wr_beat_ready,

    input  mem_slave_pkg::burst_cmd_t rd_cmd,         // read command
    input  logic                      rd_cmd_valid,
    output logic                      rd_cmd_ready,

    output mem_slave_pkg::rd_beat_t   rd_beat,        // read data
    output logic                      rd_beat_valid,
    input  logic                      rd_beat_ready
);
    import mem_slave_pkg::*;

    word_wr_t                  word_wr;
    logic                      word_wr_valid;
    logic                      word_wr_ready;
    logic [STORE_IDX_BITS-1:0] word_rd_idx;
    logic                      word_rd_valid;
    logic                      word_rd_ready;
    word_rd_t                  word_rd;
    logic                      word_rd_resp_valid;

    write_beat_packer i_packer (
        .clk           (clk          ),
        .rst           (rst          ),
        .init_done     (init_done    ),
        .wr_cmd        (wr_cmd       ),
        .wr_cmd_valid  (wr_cmd_valid ),
        .wr_cmd_ready  (wr_cmd_ready ),
        .wr_beat       (wr_beat      ),
        .wr_beat_valid (wr_beat_valid),
        .wr_beat_ready (wr_beat_ready),
        .word_wr       (word_wr      ),
        .word_wr_valid (word_wr_valid),
        .word_wr_ready (word_wr_ready)
    );

    read_beat_splitter i_splitter (
        .clk                (clk               ),
        .rst                (rst               ),
        .init_done          (init_done         ),
        .rd_cmd             (rd_cmd            ),
        .rd_cmd_valid       (rd_cmd_valid      ),
        .rd_cmd_ready       (rd_cmd_ready      ),
        .word_rd_idx        (word_rd_idx       ),
        .word_rd_valid      (word_rd_valid     ),
        .word_rd_ready      (word_rd_ready     ),
        .word_rd            (word_rd           ),
        .word_rd_resp_valid (word_rd_resp_valid),
        .rd_beat            (rd_beat           ),
        .rd_beat_valid      (rd_beat_valid     ),
        .rd_beat_ready      (rd_beat_ready     )
    );

    // stands in for the DDR3 controller
    wide_word_store i_store (
        .clk                (clk               ),
        .rst                (rst               ),
        .init_done          (init_done         ),
        .word_wr            (word_wr           ),
        .word_wr_valid      (word_wr_valid     ),
        .word_wr_ready      (word_wr_ready     ),
        .word_rd_idx        (word_rd_idx       ),
        .word_rd_valid      (word_rd_valid     ),
        .word_rd_ready      (word_rd_ready     ),
        .word_rd            (word_rd           ),
        .word_rd_resp_valid (word_rd_resp_valid)
    );

endmodule

//--- hdl/wide_word_store.sv
`timescale 1ns/100ps

module wide_word_store (
    input  logic                                     clk,
    input  logic                                     rst,
    output logic                                     init_done,

    input  mem_slave_pkg::word_wr_t                  word_wr,
    input  logic                                     word_wr_valid,
    output logic                                     word_wr_ready,

    input  logic [mem_slave_pkg::STORE_IDX_BITS-1:0] word_rd_idx,
    input  logic                                     word_rd_valid,
    output logic                                     word_rd_ready,

    output mem_slave_pkg::word_rd_t                  word_rd,
    output logic                                     word_rd_resp_valid
);
    import mem_slave_pkg::*;

    logic [WORD_BITS-1:0]      mem [STORE_WORDS];
    logic [STORE_IDX_BITS-1:0] clr_idx;        // word cleared this cycle
    logic                      wr_fire;
    logic                      rd_fire;
    logic [READ_LATENCY-1:0]   rd_vld_pipe;
    logic [WORD_BITS-1:0]      rd_data_pipe [READ_LATENCY];

    // single port, write wins over read
    assign word_wr_ready = init_done;
    assign word_rd_ready = init_done && !word_wr_valid;

    assign wr_fire = word_wr_valid && word_wr_ready;
    assign rd_fire = word_rd_valid && word_rd_ready;

    assign word_rd.data       = rd_data_pipe[READ_LATENCY-1];
    assign word_rd_resp_valid = rd_vld_pipe[READ_LATENCY-1];

    // clear phase, then the read valid pipeline
    always_ff @(posedge clk) begin
        if (rst) begin
            init_done   <= 1'b0;
            clr_idx     <= '0;
            rd_vld_pipe <= '0;
        end else begin
            if (!init_done) begin
                clr_idx <= clr_idx + 1'b1;
                if (clr_idx == STORE_IDX_BITS'(STORE_WORDS - 1)) begin
                    init_done <= 1'b1;                  // stays set until reset
                end
            end
            rd_vld_pipe[0] <= rd_fire;
            for (int i = 1; i < READ_LATENCY; i++) begin
                rd_vld_pipe[i] <= rd_vld_pipe[i-1];
            end
        end
    end

    // memory array with byte merge under the strobe
    always_ff @(posedge clk) begin
        if (!init_done) begin
            mem[clr_idx] <= '0;
        end else if (wr_fire) begin
            for (int b = 0; b < WORD_STRB_BITS; b++) begin
                if (word_wr.strb[b]) begin
                    mem[word_wr.idx][b*8 +: 8] <= word_wr.data[b*8 +: 8];
                end
            end
        end
    end

    // read data pipeline
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rd_data_pipe[0] <= mem[word_rd_idx];
        end
        for (int i = 1; i < READ_LATENCY; i++) begin
            rd_data_pipe[i] <= rd_data_pipe[i-1];
        end
    end

endmodule

//--- hdl/read_beat_splitter.sv
`timescale 1ns/100ps

module read_beat_splitter (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic                                     init_done,

    input  mem_slave_pkg::burst_cmd_t                rd_cmd,
    input  logic                                     rd_cmd_valid,
    output logic                                     rd_cmd_ready,

    output logic [mem_slave_pkg::STORE_IDX_BITS-1:0] word_rd_idx,
    output logic                                     word_rd_valid,
    input  logic                                     word_rd_ready,

    input  mem_slave_pkg::word_rd_t                  word_rd,
    input  logic                                     word_rd_resp_valid,

    output mem_slave_pkg::rd_beat_t                  rd_beat,
    output logic                                     rd_beat_valid,
    input  logic                                     rd_beat_ready
);
    import mem_slave_pkg::*;

    logic                      busy;
    logic                      req_pend;       // word request waiting for the store
    logic                      buf_valid;      // word buffer holds beats
    logic [STORE_IDX_BITS-1:0] cur_idx;
    logic [LANE_BITS-1:0]      lane;           // lane of the beat on offer
    logic [LEN_BITS-1:0]       beats_left;     // beats after the one on offer
    logic [WORD_BITS-1:0]      buf_data;
    logic                      cmd_fire;
    logic                      req_fire;
    logic                      beat_fire;
    logic                      final_beat;

    assign cmd_fire   = rd_cmd_valid && rd_cmd_ready;
    assign req_fire   = word_rd_valid && word_rd_ready;
    assign beat_fire  = rd_beat_valid && rd_beat_ready;
    assign final_beat = (beats_left == '0);

    assign rd_cmd_ready  = init_done && !busy;
    assign word_rd_idx   = cur_idx;
    assign word_rd_valid = req_pend;
    assign rd_beat_valid = buf_valid;

    always_comb begin
        rd_beat.data = buf_data[lane*BEAT_BITS +: BEAT_BITS];
        rd_beat.last = final_beat;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy       <= 1'b0;
            req_pend   <= 1'b0;
            buf_valid  <= 1'b0;
            cur_idx    <= '0;
            lane       <= '0;
            beats_left <= '0;
        end else begin
            if (req_fire) begin
                req_pend <= 1'b0;
            end
            if (word_rd_resp_valid) begin
                buf_valid <= 1'b1;                      // only one request in flight
            end
            if (cmd_fire) begin
                busy       <= 1'b1;
                req_pend   <= 1'b1;
                cur_idx    <= rd_cmd.addr.fields.word_idx[STORE_IDX_BITS-1:0];
                lane       <= rd_cmd.addr.fields.lane;
                beats_left <= rd_cmd.len;
            end else if (beat_fire) begin
                beats_left <= beats_left - 1'b1;
                if (final_beat) begin
                    busy      <= 1'b0;
                    buf_valid <= 1'b0;
                end else if (lane == LANE_BITS'(BEATS_PER_WORD - 1)) begin
                    buf_valid <= 1'b0;                  // buffer empties, fetch next word
                    req_pend  <= 1'b1;
                    cur_idx   <= cur_idx + 1'b1;
                    lane      <= '0;
                end else begin
                    lane <= lane + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (word_rd_resp_valid) begin
            buf_data <= word_rd.data;
        end
    end

endmodule

//--- hdl/write_beat_packer.sv
`timescale 1ns/100ps

module write_beat_packer (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      init_done,

    input  mem_slave_pkg::burst_cmd_t wr_cmd,
    input  logic                      wr_cmd_valid,
    output logic                      wr_cmd_ready,

    input  mem_slave_pkg::wr_beat_t   wr_beat,
    input  logic                      wr_beat_valid,
    output logic                      wr_beat_ready,

    output mem_slave_pkg::word_wr_t   word_wr,
    output logic                      word_wr_valid,
    input  logic                      word_wr_ready
);
    import mem_slave_pkg::*;

    logic                      busy;           // burst in progress
    logic [STORE_IDX_BITS-1:0] cur_idx;        // word being assembled
    logic [LANE_BITS-1:0]      lane;           // lane of the next beat
    logic [LEN_BITS-1:0]       beats_left;     // beats after the current one
    logic [WORD_BITS-1:0]      asm_data;
    logic [WORD_STRB_BITS-1:0] asm_strb;
    logic [WORD_BITS-1:0]      asm_data_nxt;
    logic [WORD_STRB_BITS-1:0] asm_strb_nxt;
    logic                      cmd_fire;
    logic                      beat_fire;
    logic                      burst_end;
    logic                      word_done;

    assign cmd_fire  = wr_cmd_valid && wr_cmd_ready;
    assign beat_fire = wr_beat_valid && wr_beat_ready;

    // last flag ends the burst, the count covers a missing last
    assign burst_end = wr_beat.last || (beats_left == '0);
    assign word_done = burst_end || (lane == LANE_BITS'(BEATS_PER_WORD - 1));

    // idle only once the final word has left
    assign wr_cmd_ready  = init_done && !busy && !word_wr_valid;
    // hold beats while the output word is stuck
    assign wr_beat_ready = busy && (!word_wr_valid || word_wr_ready);

    // merge the incoming beat into its lane
    always_comb begin
        asm_data_nxt = asm_data;
        asm_strb_nxt = asm_strb;
        asm_data_nxt[lane*BEAT_BITS +: BEAT_BITS]           = wr_beat.data;
        asm_strb_nxt[lane*BEAT_STRB_BITS +: BEAT_STRB_BITS] = wr_beat.strb;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy          <= 1'b0;
            cur_idx       <= '0;
            lane          <= '0;
            beats_left    <= '0;
            word_wr_valid <= 1'b0;
        end else begin
            if (word_wr_ready) begin
                word_wr_valid <= 1'b0;                  // store took the word
            end
            if (cmd_fire) begin
                busy       <= 1'b1;
                cur_idx    <= wr_cmd.addr.fields.word_idx[STORE_IDX_BITS-1:0];
                lane       <= wr_cmd.addr.fields.lane;
                beats_left <= wr_cmd.len;
            end else if (beat_fire) begin
                beats_left <= beats_left - 1'b1;
                if (word_done) begin
                    word_wr_valid <= 1'b1;
                    cur_idx       <= cur_idx + 1'b1;    // wraps, so index aliases
                    lane          <= '0;
                end else begin
                    lane <= lane + 1'b1;
                end
                if (burst_end) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    // assembly buffer and output word
    always_ff @(posedge clk) begin
        if (cmd_fire) begin
            asm_data <= '0;
            asm_strb <= '0;                             // untouched bytes stay unwritten
        end else if (beat_fire) begin
            if (word_done) begin
                word_wr.idx  <= cur_idx;
                word_wr.data <= asm_data_nxt;
                word_wr.strb <= asm_strb_nxt;
                asm_data     <= '0;
                asm_strb     <= '0;
            end else begin
                asm_data <= asm_data_nxt;
                asm_strb <= asm_strb_nxt;
            end
        end
    end

endmodule

//--- hdl/mem_slave_pkg.sv
package mem_slave_pkg;

    localparam int BEAT_BITS      = 32;     // bus beat width
    localparam int WORD_BITS      = 256;    // memory word width
    localparam int BEATS_PER_WORD = 8;
    localparam int ADDR_BITS      = 28;     // bus byte address
    localparam int LEN_BITS       = 8;      // burst has len+1 beats
    localparam int STORE_WORDS    = 64;
    localparam int STORE_IDX_BITS = 6;      // higher word index bits alias
    localparam int READ_LATENCY   = 2;      // accepted request to word

    localparam int BEAT_STRB_BITS = BEAT_BITS / 8;
    localparam int WORD_STRB_BITS = WORD_BITS / 8;
    localparam int LANE_BITS      = $clog2(BEATS_PER_WORD);
    localparam int BYTE_OFF_BITS  = $clog2(BEAT_STRB_BITS);
    localparam int WORD_IDX_BITS  = ADDR_BITS - LANE_BITS - BYTE_OFF_BITS;

    // field view of a byte address
    typedef struct packed {
        logic [WORD_IDX_BITS-1:0] word_idx;
        logic [LANE_BITS-1:0]     lane;       // beat position in the word
        logic [BYTE_OFF_BITS-1:0] byte_off;   // ignored
    } addr_fields_t;

    typedef union packed {
        logic [ADDR_BITS-1:0] flat;
        addr_fields_t         fields;
    } bus_addr_u;

    // write or read command
    typedef struct packed {
        bus_addr_u            addr;
        logic [LEN_BITS-1:0]  len;
    } burst_cmd_t;

    typedef struct packed {
        logic [BEAT_BITS-1:0]      data;
        logic [BEAT_STRB_BITS-1:0] strb;
        logic                      last;
    } wr_beat_t;

    typedef struct packed {
        logic [BEAT_BITS-1:0] data;
        logic                 last;
    } rd_beat_t;

    // byte b of the word belongs to lane b/4
    typedef struct packed {
        logic [STORE_IDX_BITS-1:0] idx;
        logic [WORD_BITS-1:0]      data;
        logic [WORD_STRB_BITS-1:0] strb;
    } word_wr_t;

    typedef struct packed {
        logic [WORD_BITS-1:0] data;
    } word_rd_t;

endpackage
